//--- list.f
+incdir+src
src/zxuno_bus_pkg.sv
src/zxuno_cfg_pkg.sv
src/clock_enables.sv
src/zxuno_regs_port.sv
src/video_ctrl_regs.sv
src/devopts_ay_decode.sv
src/cpu_read_mux.sv
src/zxuno_io_top.sv
bench/zxuno_io_properties.sv
bench/zxuno_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module zxuno_io_tb -Mdir obj_dir -f list.f \
  && ./obj_dir/Vzxuno_io_tb | tee /dev/stderr | grep -q "All checks passed" \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

//--- bench/zxuno_io_tb.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module zxuno_io_tb;

  import zxuno_bus_pkg::*;
  import zxuno_cfg_pkg::*;

  // test lengths
  localparam int REG_ITERS  = 300;
  localparam int ADDR_ITERS = 20;
  localparam int AY_VECTORS = 100;
  localparam int IDLE_READS = 50;
  localparam int CLK_WINDOW = 64;
  localparam int SETTLE     = 10;
  // a write takes 5 cycles, a read 2, plus reset and the clock windows
  localparam int MAX_CYCLES = 8 + REG_ITERS * 17 + ADDR_ITERS * 7 +
                              2 * (10 + AY_VECTORS + 1) + 4 * (10 + 16 + CLK_WINDOW) +
                              IDLE_READS * 2 + 500;

  logic        sysclk;
  logic        rst;
  io_bus_t     bus;
  cpu_data_t   cpu_din;
  logic        cpu_oe;
  clk_en_t     clk_en;
  scandbl_t    scandbl;
  raster_cfg_t raster;
  devopts_t    devopts;
  logic        ay_bdir;
  logic        ay_bc1;

  integer      seed;
  int          cycles;
  // divider phase as the model sees it
  logic [2:0]  phase_m;

  // reference copy of the registers
  zxreg_num_t  m_num;
  scandbl_t    m_scandbl;
  raster_cfg_t m_raster;
  devopts_t    m_devopts;

  zxuno_io_top DUT (
    .sysclk  (sysclk),
    .rst     (rst),
    .bus     (bus),
    .cpu_din (cpu_din),
    .cpu_oe  (cpu_oe),
    .clk_en  (clk_en),
    .scandbl (scandbl),
    .raster  (raster),
    .devopts (devopts),
    .ay_bdir (ay_bdir),
    .ay_bc1  (ay_bc1)
  );

  // 25 MHz in sim time, stands for the 28 MHz sysclk
  always #20 sysclk = ~sysclk;

  always @(posedge sysclk) begin
    if (rst) begin
      phase_m <= 3'd0;
    end else begin
      phase_m <= phase_m + 3'd1;
    end
  end

  // --------------------------------------------------------------------------
  // watchdog and bound assertion monitor
  // --------------------------------------------------------------------------
  always @(posedge sysclk) begin
    cycles <= cycles + 1;
    if (DUT.u_props.fail_count != 0) begin
      stop_on_error("a bound assertion on the top level failed");
    end else if (cycles >= MAX_CYCLES) begin
      stop_on_error("timeout, the test sequence did not finish within the cycle limit");
    end
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_read(input cpu_data_t exp_d, input logic exp_oe);
    if (cpu_din !== exp_d || cpu_oe !== exp_oe) begin
      stop_on_error($sformatf("[ERROR] cpu_din/cpu_oe got %h/%h expected %h/%h",
                              cpu_din, cpu_oe, exp_d, exp_oe));
    end
  endtask

  task automatic check_scandbl(input scandbl_t exp);
    if (scandbl !== exp) begin
      stop_on_error($sformatf("[ERROR] scandbl got %h expected %h", scandbl, exp));
    end
  endtask

  task automatic check_raster(input raster_cfg_t exp);
    if (raster !== exp) begin
      stop_on_error($sformatf("[ERROR] raster got %h expected %h", raster, exp));
    end
  endtask

  task automatic check_devopts(input devopts_t exp);
    if (devopts !== exp) begin
      stop_on_error($sformatf("[ERROR] devopts got %h expected %h", devopts, exp));
    end
  endtask

  task automatic check_clk_en(input clk_en_t exp);
    if (clk_en !== exp) begin
      stop_on_error($sformatf("[ERROR] clk_en got %h expected %h", clk_en, exp));
    end
  endtask

  task automatic check_ay(input logic exp_bdir, input logic exp_bc1);
    if (ay_bdir !== exp_bdir || ay_bc1 !== exp_bc1) begin
      stop_on_error($sformatf("[ERROR] ay_bdir/ay_bc1 got %h/%h expected %h/%h",
                              ay_bdir, ay_bc1, exp_bdir, exp_bc1));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("[ERROR] %s pulses got %h expected %h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // bus cycles, driven on the falling edge
  // --------------------------------------------------------------------------
  task automatic drive_idle();
    bus.addr   = 16'h0000;
    bus.dout   = 8'h00;
    bus.iorq_n = 1'b1;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b1;
  endtask

  // held 4 cycles, then 1 idle
  task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data);
    @(negedge sysclk);
    bus.addr   = addr;
    bus.dout   = data;
    bus.iorq_n = 1'b0;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b0;
    repeat (4) @(negedge sysclk);
    drive_idle();
  endtask

  // one cycle, data checked mid cycle
  task automatic bus_read(input cpu_addr_t addr, input cpu_data_t exp_d, input logic exp_oe);
    @(negedge sysclk);
    bus.addr   = addr;
    bus.iorq_n = 1'b0;
    bus.rd_n   = 1'b0;
    bus.wr_n   = 1'b1;
    #SETTLE;
    check_read(exp_d, exp_oe);
    @(negedge sysclk);
    drive_idle();
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  task automatic model_write(input zxreg_num_t num, input cpu_data_t data);
    case (num)
      `REG_SCANDBL: begin
        m_scandbl.vga_enable       = data[0];
        m_scandbl.scanlines_enable = data[1];
        m_scandbl.freq_option      = data[4:2];
        m_scandbl.cpu_speed        = cpu_speed_e'(data[7:6]);
      end
      `REG_RASTER_LINE: begin
        m_raster.line[7:0] = data;
      end
      `REG_RASTER_CTRL: begin
        m_raster.line[8]          = data[0];
        m_raster.vretrace_disable = data[1];
        m_raster.enable           = data[2];
      end
      `REG_DEVOPTIONS: begin
        m_devopts = devopts_t'(data);
      end
      default: begin
      end
    endcase
  endtask

  // unknown numbers float the bus
  function automatic rd_src_t model_read(input zxreg_num_t num);
    rd_src_t r;
    r.data = 8'h00;
    r.oe   = 1'b1;
    case (num)
      `REG_SCANDBL: r.data = {m_scandbl.cpu_speed, 1'b0, m_scandbl.freq_option,
                              m_scandbl.scanlines_enable, m_scandbl.vga_enable};
      `REG_RASTER_LINE: r.data = m_raster.line[7:0];
      `REG_RASTER_CTRL: r.data = {5'b00000, m_raster.enable, m_raster.vretrace_disable,
                                  m_raster.line[8]};
      `REG_DEVOPTIONS: r.data = m_devopts;
      default: begin
        r.data = 8'hFF;
        r.oe   = 1'b0;
      end
    endcase
    return r;
  endfunction

  // 3.5 MHz on phase 7, cpu follows the chosen enable
  function automatic clk_en_t expected_clk_en(input cpu_speed_e spd);
    clk_en_t e;
    e.clk14en = phase_m[0];
    e.clk7en  = (phase_m[1:0] == 2'b11);
    e.clk35en = (phase_m == 3'd7);
    case (spd)
      speed_3m5: e.clkcpu_enable = e.clk35en;
      speed_7m:  e.clkcpu_enable = e.clk7en;
      speed_14m: e.clkcpu_enable = e.clk14en;
      default:   e.clkcpu_enable = 1'b1;
    endcase
    return e;
  endfunction

  task automatic check_outputs();
    check_scandbl(m_scandbl);
    check_raster(m_raster);
    check_devopts(m_devopts);
  endtask

  // address port then data port, model follows
  task automatic write_reg(input zxreg_num_t num, input cpu_data_t data);
    bus_write(`ZXUNO_ADDR_PORT, num);
    m_num = num;
    bus_write(`ZXUNO_DATA_PORT, data);
    model_write(num, data);
    check_outputs();
  endtask

  // mostly known registers, the rest anything
  task automatic rand_num(output zxreg_num_t num);
    logic [31:0] r;
    r = $random(seed);
    case (r[10:8])
      3'd0:    num = `REG_SCANDBL;
      3'd1:    num = `REG_RASTER_LINE;
      3'd2:    num = `REG_RASTER_CTRL;
      3'd3:    num = `REG_DEVOPTIONS;
      default: num = r[7:0];
    endcase
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    zxreg_num_t  num;
    zxreg_num_t  rnum;
    rd_src_t     exp;
    cpu_addr_t   a;
    logic        eb;
    logic        ec;
    int          cnt14;
    int          cnt7;
    int          cnt35;
    int          cntcpu;
    seed   = 32'hac8f;
    cycles = 0;
    sysclk = 1'b0;
    rst    = 1'b1;
    drive_idle();
    m_num       = '0;
    m_scandbl   = '0;
    m_raster    = '0;
    m_raster.line = `RASTER_LINE_RESET;
    m_devopts   = '0;
    repeat (4) @(posedge sysclk);
    @(negedge sysclk);
    rst = 1'b0;

    // reset values
    #SETTLE;
    check_outputs();
    check_read(8'hFF, 1'b0);
    check_ay(1'b0, 1'b0);

    // random register traffic, each write followed by a read-back
    for (int i = 0; i < REG_ITERS; i++) begin
      rand_num(num);
      r = $random(seed);
      write_reg(num, r[7:0]);
      rand_num(rnum);
      bus_write(`ZXUNO_ADDR_PORT, rnum);
      m_num = rnum;
      exp = model_read(rnum);
      bus_read(`ZXUNO_DATA_PORT, exp.data, exp.oe);
    end

    // address port read-back
    for (int i = 0; i < ADDR_ITERS; i++) begin
      r = $random(seed);
      bus_write(`ZXUNO_ADDR_PORT, r[7:0]);
      m_num = r[7:0];
      bus_read(`ZXUNO_ADDR_PORT, m_num, 1'b1);
    end

    // ay decode with disable_ay clear, then set
    for (int d = 0; d < 2; d++) begin
      r = $random(seed);
      write_reg(`REG_DEVOPTIONS, {r[7:1], d[0]});
      for (int k = 0; k < AY_VECTORS; k++) begin
        r = $random(seed);
        a = r[15:0];
        // bias towards the ay port low bits
        if (r[16]) begin
          a[1:0] = 2'b01;
        end
        // keep clear of the register ports
        if (a == `ZXUNO_ADDR_PORT || a == `ZXUNO_DATA_PORT) begin
          a[0] = ~a[0];
        end
        @(negedge sysclk);
        bus.addr   = a;
        bus.dout   = r[31:24];
        bus.iorq_n = r[17];
        bus.rd_n   = r[18];
        bus.wr_n   = r[19];
        #SETTLE;
        eb = ~m_devopts.disable_ay & a[15] & (a[1:0] == 2'b01) & ~bus.iorq_n & ~bus.wr_n;
        ec = ~m_devopts.disable_ay & a[15] & a[14] & (a[1:0] == 2'b01) & ~bus.iorq_n;
        check_ay(eb, ec);
      end
      @(negedge sysclk);
      drive_idle();
    end

    // clock enables at each speed
    for (int s = 0; s < 4; s++) begin
      r = $random(seed);
      write_reg(`REG_SCANDBL, {s[1:0], r[5:0]});
      // speed switch waits for the next phase 7
      repeat (16) @(negedge sysclk);
      cnt14  = 0;
      cnt7   = 0;
      cnt35  = 0;
      cntcpu = 0;
      for (int c = 0; c < CLK_WINDOW; c++) begin
        @(negedge sysclk);
        check_clk_en(expected_clk_en(cpu_speed_e'(s[1:0])));
        if (clk_en.clk14en) cnt14 = cnt14 + 1;
        if (clk_en.clk7en) cnt7 = cnt7 + 1;
        if (clk_en.clk35en) cnt35 = cnt35 + 1;
        if (clk_en.clkcpu_enable) cntcpu = cntcpu + 1;
      end
      check_count("clk14en", cnt14, 32);
      check_count("clk7en", cnt7, 16);
      check_count("clk35en", cnt35, 8);
      check_count("clkcpu_enable", cntcpu, 8 << s);
    end

    // nobody answers outside the two ports
    for (int i = 0; i < IDLE_READS; i++) begin
      r = $random(seed);
      a = r[15:0];
      if (a == `ZXUNO_ADDR_PORT || a == `ZXUNO_DATA_PORT) begin
        a[0] = ~a[0];
      end
      bus_read(a, 8'hFF, 1'b0);
    end

    // assertions of the last cycles are not seen by the watchdog yet
    if (DUT.u_props.fail_count != 0) begin
      stop_on_error("a bound assertion on the top level failed");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- bench/zxuno_io_properties.sv
`timescale 1ns/1ps

module zxuno_io_properties (
  input logic                      sysclk,
  input logic                      rst,
  input zxuno_bus_pkg::io_bus_t    bus,
  input logic                      cpu_oe,
  input zxuno_cfg_pkg::clk_en_t    clk_en,
  input logic                      ay_bdir,
  input logic                      wr_stb,
  input zxuno_cfg_pkg::cpu_speed_e speed_eff
);

  import zxuno_cfg_pkg::*;

  // failures so far, watched by the testbench
  int fail_count = 0;

  // bdir only inside an i/o write
  bdir_in_write: assert property (@(posedge sysclk) disable iff (rst)
    ay_bdir |-> (!bus.iorq_n && !bus.wr_n))
    else begin
      $error("ay_bdir high outside an i/o write cycle");
      fail_count = fail_count + 1;
    end

  // one strobe per data-port write
  stb_single: assert property (@(posedge sysclk) disable iff (rst)
    wr_stb |=> !wr_stb)
    else begin
      $error("wr_stb held for two cycles");
      fail_count = fail_count + 1;
    end

  // slowest speed tracks the 3.5 MHz enable
  cpu_at_3m5: assert property (@(posedge sysclk) disable iff (rst)
    (speed_eff == speed_3m5) |-> (clk_en.clkcpu_enable == clk_en.clk35en))
    else begin
      $error("clkcpu_enable differs from clk35en at 3.5 MHz");
      fail_count = fail_count + 1;
    end

  // no read data without iorq
  oe_needs_iorq: assert property (@(posedge sysclk) disable iff (rst)
    bus.iorq_n |-> !cpu_oe)
    else begin
      $error("cpu_oe high while iorq_n is high");
      fail_count = fail_count + 1;
    end

endmodule

bind zxuno_io_top zxuno_io_properties u_props (
  .sysclk    (sysclk),
  .rst       (rst),
  .bus       (bus),
  .cpu_oe    (cpu_oe),
  .clk_en    (clk_en),
  .ay_bdir   (ay_bdir),
  .wr_stb    (reg_access.wr_stb),
  .speed_eff (u_clock_enables.speed_q)
);

//--- src/zxuno_io_top.sv
`timescale 1ns/1ps

module zxuno_io_top (
  input  logic                       sysclk,
  input  logic                       rst,
  input  zxuno_bus_pkg::io_bus_t     bus,
  output zxuno_bus_pkg::cpu_data_t   cpu_din,
  output logic                       cpu_oe,
  output zxuno_cfg_pkg::clk_en_t     clk_en,
  output zxuno_cfg_pkg::scandbl_t    scandbl,
  output zxuno_cfg_pkg::raster_cfg_t raster,
  output zxuno_cfg_pkg::devopts_t    devopts,
  output logic                       ay_bdir,
  output logic                       ay_bc1
);

  import zxuno_bus_pkg::*;

  // register access from the port block
  reg_access_t reg_access;

  // read-back sources
  rd_src_t addr_rd;
  rd_src_t video_rd;
  rd_src_t devopts_rd;

  // --------------------------------------------------------------------------
  // clocking
  // --------------------------------------------------------------------------
  clock_enables u_clock_enables (
    .sysclk    (sysclk),
    .rst       (rst),
    .cpu_speed (scandbl.cpu_speed),
    .clk_en    (clk_en)
  );

  // --------------------------------------------------------------------------
  // register ports and register groups
  // --------------------------------------------------------------------------
  zxuno_regs_port u_regs_port (
    .sysclk     (sysclk),
    .rst        (rst),
    .bus        (bus),
    .reg_access (reg_access),
    .addr_rd    (addr_rd)
  );

  video_ctrl_regs u_video_ctrl_regs (
    .sysclk     (sysclk),
    .rst        (rst),
    .reg_access (reg_access),
    .scandbl    (scandbl),
    .raster     (raster),
    .rd         (video_rd)
  );

  // options plus the ay decode they gate
  devopts_ay_decode u_devopts_ay (
    .sysclk     (sysclk),
    .rst        (rst),
    .bus        (bus),
    .reg_access (reg_access),
    .devopts    (devopts),
    .rd         (devopts_rd),
    .ay_bdir    (ay_bdir),
    .ay_bc1     (ay_bc1)
  );

  // data back to the cpu
  cpu_read_mux u_cpu_read_mux (
    .addr_rd    (addr_rd),
    .video_rd   (video_rd),
    .devopts_rd (devopts_rd),
    .cpu_din    (cpu_din),
    .cpu_oe     (cpu_oe)
  );

endmodule

//--- src/cpu_read_mux.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module cpu_read_mux (
  input  zxuno_bus_pkg::rd_src_t    addr_rd,
  input  zxuno_bus_pkg::rd_src_t    video_rd,
  input  zxuno_bus_pkg::rd_src_t    devopts_rd,
  output zxuno_bus_pkg::cpu_data_t  cpu_din,
  output logic                      cpu_oe
);

  // --------------------------------------------------------------------------
  // priority select, first source with oe wins
  // --------------------------------------------------------------------------
  always_comb begin
    cpu_oe = 1'b1;
    case (1'b1)
      // address port first
      addr_rd.oe: begin
        cpu_din = addr_rd.data;
      end
      // then 0b..0d
      video_rd.oe: begin
        cpu_din = video_rd.data;
      end
      // then 0e
      devopts_rd.oe: begin
        cpu_din = devopts_rd.data;
      end
      // nobody claims the bus, pull-ups
      default: begin
        cpu_din = `BUS_IDLE_DATA;
        cpu_oe  = 1'b0;
      end
    endcase
  end

endmodule

//--- src/devopts_ay_decode.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module devopts_ay_decode (
  input  logic                       sysclk,
  input  logic                       rst,
  input  zxuno_bus_pkg::io_bus_t     bus,
  input  zxuno_bus_pkg::reg_access_t reg_access,
  output zxuno_cfg_pkg::devopts_t    devopts,
  output zxuno_bus_pkg::rd_src_t     rd,
  output logic                       ay_bdir,
  output logic                       ay_bc1
);

  import zxuno_cfg_pkg::*;

  // register 0e selected
  logic hit;

  // common part of the ay port decode
  logic ay_sel;

  assign hit = (reg_access.num == `REG_DEVOPTIONS);

  // --------------------------------------------------------------------------
  // device option register
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      devopts <= '0;
    end else if (reg_access.wr_stb && hit) begin
      // struct order matches the register bits
      devopts <= devopts_t'(reg_access.data);
    end
  end

  // read-back, whole byte
  always_comb begin
    rd.data = devopts;
    rd.oe   = reg_access.rd & hit;
  end

  // --------------------------------------------------------------------------
  // ay bus decode
  //   bdir bc1
  //    0    0   inactive
  //    0    1   read
  //    1    0   write
  //    1    1   latch address
  // --------------------------------------------------------------------------
  assign ay_sel = bus.addr[`AY_ADDR_BDIR_BIT] &
                  (bus.addr[1:0] == `AY_PORT_LSBS) &
                  ~bus.iorq_n &
                  ~devopts.disable_ay;

  // write or address latch
  assign ay_bdir = ay_sel & ~bus.wr_n;

  // a14 selects register/read side
  assign ay_bc1 = ay_sel & bus.addr[`AY_ADDR_BC1_BIT];

endmodule

//--- src/video_ctrl_regs.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module video_ctrl_regs (
  input  logic                       sysclk,
  input  logic                       rst,
  input  zxuno_bus_pkg::reg_access_t reg_access,
  output zxuno_cfg_pkg::scandbl_t    scandbl,
  output zxuno_cfg_pkg::raster_cfg_t raster,
  output zxuno_bus_pkg::rd_src_t     rd
);

  import zxuno_cfg_pkg::*;

  // register hits
  logic hit_scandbl;
  logic hit_rline;
  logic hit_rctrl;

  assign hit_scandbl = (reg_access.num == `REG_SCANDBL);
  assign hit_rline   = (reg_access.num == `REG_RASTER_LINE);
  assign hit_rctrl   = (reg_access.num == `REG_RASTER_CTRL);

  // --------------------------------------------------------------------------
  // register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      scandbl.vga_enable       <= 1'b0;
      scandbl.scanlines_enable <= 1'b0;
      scandbl.freq_option      <= 3'd0;
      scandbl.cpu_speed        <= speed_3m5;
      raster.line              <= `RASTER_LINE_RESET;
      raster.vretrace_disable  <= 1'b0;
      raster.enable            <= 1'b0;
    end else if (reg_access.wr_stb) begin
      // 0b, bit 5 is not stored
      if (hit_scandbl) begin
        scandbl.vga_enable       <= reg_access.data[`SCANDBL_VGA_BIT];
        scandbl.scanlines_enable <= reg_access.data[`SCANDBL_SCANL_BIT];
        scandbl.freq_option      <= reg_access.data[`SCANDBL_FREQ_MSB:`SCANDBL_FREQ_LSB];
        scandbl.cpu_speed        <=
          cpu_speed_e'(reg_access.data[`SCANDBL_SPEED_MSB:`SCANDBL_SPEED_LSB]);
      end
      // 0c, low byte of the line
      if (hit_rline) begin
        raster.line[7:0] <= reg_access.data;
      end
      // 0d, line msb plus the two flags
      if (hit_rctrl) begin
        raster.line[8]          <= reg_access.data[`RCTRL_LINE8_BIT];
        raster.vretrace_disable <= reg_access.data[`RCTRL_VRET_BIT];
        raster.enable           <= reg_access.data[`RCTRL_EN_BIT];
      end
    end
  end

  // --------------------------------------------------------------------------
  // read-back, unused bits zero
  // --------------------------------------------------------------------------
  always_comb begin
    rd.data = 8'h00;
    rd.oe   = reg_access.rd & (hit_scandbl | hit_rline | hit_rctrl);
    if (hit_scandbl) begin
      rd.data[`SCANDBL_VGA_BIT]                     = scandbl.vga_enable;
      rd.data[`SCANDBL_SCANL_BIT]                   = scandbl.scanlines_enable;
      rd.data[`SCANDBL_FREQ_MSB:`SCANDBL_FREQ_LSB]   = scandbl.freq_option;
      rd.data[`SCANDBL_SPEED_MSB:`SCANDBL_SPEED_LSB] = scandbl.cpu_speed;
    end else if (hit_rline) begin
      rd.data = raster.line[7:0];
    end else if (hit_rctrl) begin
      rd.data[`RCTRL_LINE8_BIT] = raster.line[8];
      rd.data[`RCTRL_VRET_BIT]  = raster.vretrace_disable;
      rd.data[`RCTRL_EN_BIT]    = raster.enable;
    end
  end

endmodule

//--- src/zxuno_regs_port.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module zxuno_regs_port (
  input  logic                       sysclk,
  input  logic                       rst,
  input  zxuno_bus_pkg::io_bus_t     bus,
  output zxuno_bus_pkg::reg_access_t reg_access,
  output zxuno_bus_pkg::rd_src_t     addr_rd
);

  import zxuno_bus_pkg::*;

  // port decode
  logic addr_sel;
  logic data_sel;

  // bus cycle levels
  logic io_rd;
  logic io_wr;

  // write level seen at the previous edge
  logic wr_q;
  logic wr_start;

  // current register number, fc3b
  zxreg_num_t reg_num;

  // strobe and what it carries
  logic       wr_stb;
  zxreg_num_t stb_num;
  cpu_data_t  stb_data;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  assign addr_sel = (bus.addr == `ZXUNO_ADDR_PORT);
  assign data_sel = (bus.addr == `ZXUNO_DATA_PORT);
  assign io_rd    = ~bus.iorq_n & ~bus.rd_n;
  assign io_wr    = ~bus.iorq_n & ~bus.wr_n;

  // first sampled cycle of a write, the rest of a held access is ignored
  assign wr_start = io_wr & ~wr_q;

  // --------------------------------------------------------------------------
  // control state
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      wr_q    <= 1'b0;
      wr_stb  <= 1'b0;
      reg_num <= '0;
    end else begin
      wr_q   <= io_wr;
      wr_stb <= wr_start & data_sel;
      // address port takes effect right at the sampling edge
      if (wr_start && addr_sel) begin
        reg_num <= bus.dout;
      end
    end
  end

  // captured number and data for the strobe cycle
  always_ff @(posedge sysclk) begin
    if (wr_start && data_sel) begin
      stb_num  <= reg_num;
      stb_data <= bus.dout;
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  always_comb begin
    reg_access.num    = wr_stb ? stb_num : reg_num;
    reg_access.data   = stb_data;
    reg_access.rd     = data_sel & io_rd;
    reg_access.wr_stb = wr_stb;
  end

  // read-back of the register number
  always_comb begin
    addr_rd.data = reg_num;
    addr_rd.oe   = addr_sel & io_rd;
  end

endmodule

//--- src/clock_enables.sv
`timescale 1ns/1ps
`include "zxuno_macros.svh"

module clock_enables (
  input  logic                       sysclk,
  input  logic                       rst,
  input  zxuno_cfg_pkg::cpu_speed_e  cpu_speed,
  output zxuno_cfg_pkg::clk_en_t     clk_en
);

  import zxuno_cfg_pkg::*;

  // free-running phase of sysclk, one period of the 3.5 MHz enable
  logic [2:0] phase;

  // speed actually used for the cpu enable
  cpu_speed_e speed_q;

  // last phase, all enables line up here
  logic boundary;

  assign boundary = (phase == `CLKEN_PHASE_LAST);

  // --------------------------------------------------------------------------
  // divider and speed switch
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (rst) begin
      phase   <= 3'd0;
      speed_q <= speed_3m5;
    end else begin
      phase <= phase + 3'd1;
      // new speed starts with phase 0, so no short cpu period
      if (boundary) begin
        speed_q <= cpu_speed;
      end
    end
  end

  // --------------------------------------------------------------------------
  // enables
  // --------------------------------------------------------------------------
  always_comb begin
    clk_en.clk14en = phase[0];
    clk_en.clk7en  = (phase[1:0] == 2'b11);
    clk_en.clk35en = boundary;
    // cpu follows one of the pixel enables
    case (speed_q)
      speed_3m5: clk_en.clkcpu_enable = clk_en.clk35en;
      speed_7m:  clk_en.clkcpu_enable = clk_en.clk7en;
      speed_14m: clk_en.clkcpu_enable = clk_en.clk14en;
      default:   clk_en.clkcpu_enable = 1'b1;
    endcase
  end

endmodule

//--- src/zxuno_cfg_pkg.sv
package zxuno_cfg_pkg;

  // cpu clock selection, encoded as in bits 7:6 of register 0b
  typedef enum logic [1:0] {
    speed_3m5 = 2'd0,
    speed_7m  = 2'd1,
    speed_14m = 2'd2,
    speed_28m = 2'd3
  } cpu_speed_e;

  // --------------------------------------------------------------------------
  // configuration outputs
  // --------------------------------------------------------------------------

  // scandoubler and cpu speed, register 0b
  typedef struct packed {
    logic       vga_enable;
    logic       scanlines_enable;
    logic [2:0] freq_option;
    cpu_speed_e cpu_speed;
  } scandbl_t;

  // raster interrupt, registers 0c and 0d
  typedef struct packed {
    logic [8:0] line;
    logic       vretrace_disable;
    logic       enable;
  } raster_cfg_t;

  // device options, register 0e
  // packed order is the register bit order, disable_ay ends up in bit 0
  typedef struct packed {
    logic disable_mixer;
    logic disable_specdrum;
    logic disable_ulaplus;
    logic disable_timexscr;
    logic disable_spisd;
    logic disable_1ffd;
    logic disable_turboay;
    logic disable_ay;
  } devopts_t;

  // clock enables derived from the 28 MHz sysclk
  typedef struct packed {
    logic clk14en;
    logic clk7en;
    logic clk35en;
    logic clkcpu_enable;
  } clk_en_t;

endpackage

//--- src/zxuno_bus_pkg.sv
package zxuno_bus_pkg;

  // --------------------------------------------------------------------------
  // plain widths of the z80 i/o bus
  // --------------------------------------------------------------------------

  // 16-bit port address
  typedef logic [15:0] cpu_addr_t;

  // one data byte, both directions
  typedef logic [7:0] cpu_data_t;

  // zx-uno register number, as written to fc3b
  typedef logic [7:0] zxreg_num_t;

  // --------------------------------------------------------------------------
  // bundles
  // --------------------------------------------------------------------------

  // cpu side of the bus, strobes active low
  typedef struct packed {
    cpu_addr_t addr;
    cpu_data_t dout;     // data driven by the cpu
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
  } io_bus_t;

  // register access towards the register blocks
  // rd is a level, wr_stb lasts one cycle per data-port write
  typedef struct packed {
    zxreg_num_t num;
    cpu_data_t  data;
    logic       rd;
    logic       wr_stb;
  } reg_access_t;

  // one read-back source for the cpu mux
  typedef struct packed {
    cpu_data_t data;
    logic      oe;
  } rd_src_t;

endpackage

//--- src/zxuno_macros.svh
`ifndef ZXUNO_MACROS_SVH
`define ZXUNO_MACROS_SVH

// --------------------------------------------------------------------------
// zx-uno register ports, full 16-bit decode
// --------------------------------------------------------------------------
`define ZXUNO_ADDR_PORT    16'hFC3B
`define ZXUNO_DATA_PORT    16'hFD3B

// register numbers behind the data port
`define REG_SCANDBL        8'h0B
`define REG_RASTER_LINE    8'h0C
`define REG_RASTER_CTRL    8'h0D
`define REG_DEVOPTIONS     8'h0E

// raster line after reset, i.e. no line selected
`define RASTER_LINE_RESET  9'h1FF

// value on the data bus when nobody drives it
`define BUS_IDLE_DATA      8'hFF

// --------------------------------------------------------------------------
// field positions inside the registers
// --------------------------------------------------------------------------
`define SCANDBL_VGA_BIT    0
`define SCANDBL_SCANL_BIT  1
`define SCANDBL_FREQ_MSB   4
`define SCANDBL_FREQ_LSB   2
`define SCANDBL_SPEED_MSB  7
`define SCANDBL_SPEED_LSB  6
`define RCTRL_LINE8_BIT    0
`define RCTRL_VRET_BIT     1
`define RCTRL_EN_BIT       2

// ay port decode, a15 for bdir, a15 and a14 for bc1
`define AY_ADDR_BDIR_BIT   15
`define AY_ADDR_BC1_BIT    14
`define AY_PORT_LSBS       2'b01

// last phase of the 28 MHz divider, where the 3.5 MHz enable fires
`define CLKEN_PHASE_LAST   3'd7

`endif
